// File: common/pipe_config.svh
// pipeline config: widths, register file size and accepted opcodes
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

`define DATA_WIDTH   64
`define REG_COUNT    32
`define ZERO_REG     5'd31           // reads as zero, never written

// BIS r31,r31,r31
`define NOOP_INST    32'h47ff_041f

// operate-format fields
`define FLD_OPCODE   31:26
`define FLD_RA       25:21
`define FLD_RB       20:16
`define FLD_LIT      20:13
`define BIT_USE_LIT  12
`define FLD_FUNC     11:5
`define FLD_RC       4:0
`define FLD_PALFUNC  25:0

`define OPCODE_INTA  6'h10           // addq subq cmpeq
`define OPCODE_INTL  6'h11           // and bis xor
`define OPCODE_INTS  6'h12           // sll srl
`define OPCODE_PAL   6'h00           // halt only

`endif

// File: common/pipe_pkg.sv
// pipeline package: shared vector types and enums for alu op and error status
`include "pipe_config.svh"

package pipe_pkg;

  typedef logic [`DATA_WIDTH-1:0]         word_t;     // register / alu data
  typedef logic [31:0]                    inst_t;     // raw instruction
  typedef logic [$clog2(`REG_COUNT)-1:0]  reg_idx_t;  // architectural reg index
  typedef logic [7:0]                     lit_t;      // operate literal

  // alu operations
  typedef enum logic [2:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_AND,
    ALU_BIS,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_CMPEQ
  } alu_func_e;

  // halt reason, sticky until reset
  typedef enum logic [1:0] {
    NO_ERROR,
    HALTED_ON_HALT,
    HALTED_ON_ILLEGAL
  } error_code_e;

endpackage

// File: common/stage_if.sv
// stage interfaces: decoded op bundle, ex/wb result bundle and write-back port
`timescale 1ns/1ps

// id -> ex
interface op_bus_if;
  import pipe_pkg::*;
  logic       valid;
  reg_idx_t   ra_idx, rb_idx;        // source indices, used for forwarding
  word_t      rega, regb;            // register file values
  logic       use_lit;
  lit_t       lit;
  alu_func_e  alu_func;
  reg_idx_t   dest_idx;
  logic       halt, illegal;

  modport source (output valid, ra_idx, rb_idx, rega, regb, use_lit, lit,
                  alu_func, dest_idx, halt, illegal);
  modport sink   (input  valid, ra_idx, rb_idx, rega, regb, use_lit, lit,
                  alu_func, dest_idx, halt, illegal);
endinterface

// ex -> wb
interface res_bus_if;
  import pipe_pkg::*;
  logic      valid;
  reg_idx_t  dest_idx;
  word_t     result;
  logic      halt, illegal;

  modport source (output valid, dest_idx, result, halt, illegal);
  modport sink   (input  valid, dest_idx, result, halt, illegal);
endinterface

// wb -> reg file and ex forwarding
interface wb_port_if;
  import pipe_pkg::*;
  logic      wr_en;
  reg_idx_t  wr_idx;
  word_t     wr_data;

  modport source (output wr_en, wr_idx, wr_data);
  modport sink   (input  wr_en, wr_idx, wr_data);
endinterface

// File: decode/reg_file.sv
// register file: 32 x 64, two reads and one write, r31 reads as zero
`timescale 1ns/1ps
`include "pipe_config.svh"

module reg_file (
  input  logic                clock,
  input  logic                reset,
  input  pipe_pkg::reg_idx_t  ra_idx,
  input  pipe_pkg::reg_idx_t  rb_idx,
  output pipe_pkg::word_t     ra_data,
  output pipe_pkg::word_t     rb_data,
  wb_port_if.sink             wb
);
  import pipe_pkg::*;

  word_t regs [`REG_COUNT];   // storage, no reset

  // write, r31 never stored
  always_ff @(posedge clock) begin
    if (wb.wr_en && wb.wr_idx != `ZERO_REG)
      regs[wb.wr_idx] <= wb.wr_data;
  end

  // reads; same-cycle write bypass covers the distance-two hazard
  assign ra_data = (ra_idx == `ZERO_REG) ? '0 :
                   (wb.wr_en && wb.wr_idx == ra_idx) ? wb.wr_data :
                   regs[ra_idx];
  assign rb_data = (rb_idx == `ZERO_REG) ? '0 :
                   (wb.wr_en && wb.wr_idx == rb_idx) ? wb.wr_data :
                   regs[rb_idx];

  // wb_stage must already filter writes to r31
  a_no_zero_write: assert property (
    @(posedge clock) disable iff (reset)
    !(wb.wr_en && wb.wr_idx == `ZERO_REG)
  ) else $error("write to zero register");

endmodule

// File: decode/id_stage.sv
// decode stage: instruction register, operate decode and the id/ex register
`timescale 1ns/1ps
`include "pipe_config.svh"

module id_stage (
  input  logic                clock,
  input  logic                reset,
  input  pipe_pkg::inst_t     inst,
  input  logic                inst_valid,
  input  logic                halted,        // sticky, from wb
  output pipe_pkg::reg_idx_t  rf_ra_idx,
  output pipe_pkg::reg_idx_t  rf_rb_idx,
  input  pipe_pkg::word_t     rf_ra_data,
  input  pipe_pkg::word_t     rf_rb_data,
  op_bus_if.source            op
);
  import pipe_pkg::*;

  // function codes, per opcode group
  localparam logic [6:0] FN_ADDQ  = 7'h20;
  localparam logic [6:0] FN_SUBQ  = 7'h29;
  localparam logic [6:0] FN_CMPEQ = 7'h2d;
  localparam logic [6:0] FN_AND   = 7'h00;
  localparam logic [6:0] FN_BIS   = 7'h20;
  localparam logic [6:0] FN_XOR   = 7'h40;
  localparam logic [6:0] FN_SLL   = 7'h39;
  localparam logic [6:0] FN_SRL   = 7'h34;

  inst_t      ir;             // instruction register
  logic       ir_valid;
  logic       accept;
  alu_func_e  dec_func;
  logic       dec_halt, dec_illegal;
  word_t      ra_value, rb_value;

  assign accept = inst_valid && !halted;   // no handshake, never stalls

  ////////////////////
  // instruction register
  always_ff @(posedge clock) begin
    if (reset) begin
      ir       <= `NOOP_INST;
      ir_valid <= 1'b0;
    end else begin
      ir_valid <= accept;
      if (accept) ir <= inst;
    end
  end

  // opcode + func -> alu op, anything unknown is illegal
  always_comb begin
    dec_func    = ALU_BIS;
    dec_halt    = 1'b0;
    dec_illegal = 1'b0;
    case (ir[`FLD_OPCODE])
      `OPCODE_INTA: begin
        case (ir[`FLD_FUNC])
          FN_ADDQ:  dec_func = ALU_ADDQ;
          FN_SUBQ:  dec_func = ALU_SUBQ;
          FN_CMPEQ: dec_func = ALU_CMPEQ;
          default:  dec_illegal = 1'b1;
        endcase
      end
      `OPCODE_INTL: begin
        case (ir[`FLD_FUNC])
          FN_AND:  dec_func = ALU_AND;
          FN_BIS:  dec_func = ALU_BIS;
          FN_XOR:  dec_func = ALU_XOR;
          default: dec_illegal = 1'b1;
        endcase
      end
      `OPCODE_INTS: begin
        case (ir[`FLD_FUNC])
          FN_SLL:  dec_func = ALU_SLL;
          FN_SRL:  dec_func = ALU_SRL;
          default: dec_illegal = 1'b1;
        endcase
      end
      `OPCODE_PAL: begin
        if (ir[`FLD_PALFUNC] == '0) dec_halt = 1'b1;   // call_pal halt
        else dec_illegal = 1'b1;
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  // register reads, r31 forced to zero
  assign rf_ra_idx = ir[`FLD_RA];
  assign rf_rb_idx = ir[`FLD_RB];
  assign ra_value  = (rf_ra_idx == `ZERO_REG) ? '0 : rf_ra_data;
  assign rb_value  = (rf_rb_idx == `ZERO_REG) ? '0 : rf_rb_data;

  ////////////////////
  // id/ex register
  always_ff @(posedge clock) begin
    if (reset) begin
      op.valid   <= 1'b0;
      op.halt    <= 1'b0;
      op.illegal <= 1'b0;
    end else begin
      op.valid   <= ir_valid;
      op.halt    <= dec_halt;
      op.illegal <= dec_illegal;
    end
    op.ra_idx   <= rf_ra_idx;              // payload, no reset
    op.rb_idx   <= rf_rb_idx;
    op.rega     <= ra_value;
    op.regb     <= rb_value;
    op.use_lit  <= ir[`BIT_USE_LIT];
    op.lit      <= ir[`FLD_LIT];
    op.alu_func <= dec_func;
    op.dest_idx <= ir[`FLD_RC];
  end

endmodule

// File: verilog/ex_stage.sv
// execute stage: operand forwarding, operate alu and the ex/wb register
`timescale 1ns/1ps
`include "pipe_config.svh"

module ex_stage (
  input  logic        clock,
  input  logic        reset,
  op_bus_if.sink      op,
  wb_port_if.sink     wb,        // older instruction, one stage ahead
  res_bus_if.source   res
);
  import pipe_pkg::*;

  logic   fwd_a, fwd_b;
  word_t  opa, opb_reg, opb;
  word_t  alu_result;
  logic   [5:0] shamt;

  ////////////////////
  // forwarding
  // only the distance-one case lands here, wb write matches an id/ex source
  assign fwd_a = wb.wr_en && (wb.wr_idx == op.ra_idx) && (op.ra_idx != `ZERO_REG);
  assign fwd_b = wb.wr_en && (wb.wr_idx == op.rb_idx) && (op.rb_idx != `ZERO_REG);

  assign opa     = fwd_a ? wb.wr_data : op.rega;
  assign opb_reg = fwd_b ? wb.wr_data : op.regb;
  assign opb     = op.use_lit ? word_t'(op.lit) : opb_reg;  // literal zero-extended
  assign shamt   = opb[5:0];                                 // low 6 bits only

  ////////////////////
  // alu
  always_comb begin
    case (op.alu_func)
      ALU_ADDQ:  alu_result = opa + opb;
      ALU_SUBQ:  alu_result = opa - opb;
      ALU_AND:   alu_result = opa & opb;
      ALU_BIS:   alu_result = opa | opb;
      ALU_XOR:   alu_result = opa ^ opb;
      ALU_SLL:   alu_result = opa << shamt;
      ALU_SRL:   alu_result = opa >> shamt;   // logical
      ALU_CMPEQ: alu_result = (opa == opb) ? word_t'(1) : '0;
      default:   alu_result = '0;
    endcase
  end

  ////////////////////
  // ex/wb register
  always_ff @(posedge clock) begin
    if (reset) begin
      res.valid   <= 1'b0;
      res.halt    <= 1'b0;
      res.illegal <= 1'b0;
    end else begin
      res.valid   <= op.valid;
      res.halt    <= op.halt;
      res.illegal <= op.illegal;
    end
    res.dest_idx <= op.dest_idx;
    res.result   <= alu_result;
  end

  // decode must hand over a clean op for every valid slot
  a_func_known: assert property (
    @(posedge clock) disable iff (reset)
    op.valid |-> !$isunknown(op.alu_func)
  ) else $error("alu_func unknown on valid op");

endmodule

// File: verilog/wb_stage.sv
// writeback stage: register write enable, commit outputs and sticky halt status
`timescale 1ns/1ps
`include "pipe_config.svh"

module wb_stage (
  input  logic                   clock,
  input  logic                   reset,
  res_bus_if.sink                res,
  wb_port_if.source              wb,
  output logic                   commit_valid,
  output logic                   commit_wr_en,
  output pipe_pkg::reg_idx_t     commit_wr_idx,
  output pipe_pkg::word_t        commit_wr_data,
  output logic                   halted,
  output pipe_pkg::error_code_e  error_status
);
  import pipe_pkg::*;

  logic stop;   // halting commit this cycle

  // younger ops behind a halt are dropped here
  assign commit_valid = res.valid && !halted;
  assign stop         = commit_valid && (res.halt || res.illegal);

  assign wb.wr_en   = commit_valid && !res.halt && !res.illegal &&
                      (res.dest_idx != `ZERO_REG);
  assign wb.wr_idx  = res.dest_idx;
  assign wb.wr_data = res.result;

  assign commit_wr_en   = wb.wr_en;
  assign commit_wr_idx  = res.dest_idx;
  assign commit_wr_data = res.result;

  ////////////////////
  // halt latch keeps the first halt
  always_ff @(posedge clock) begin
    if (reset) begin
      halted       <= 1'b0;
      error_status <= NO_ERROR;
    end else if (stop) begin
      halted       <= 1'b1;
      error_status <= res.illegal ? HALTED_ON_ILLEGAL : HALTED_ON_HALT;
    end
  end

  // id stops accepting once halted, in-flight ops gone after three cycles
  a_halt_drain: assert property (
    @(posedge clock) disable iff (reset)
    halted && $past(halted, 3) |-> !res.valid
  ) else $error("instructions still arriving after halt");

endmodule

// File: verilog/pipeline.sv
// pipeline top: three-stage integer pipeline with commit and halt reporting
`timescale 1ns/1ps

module pipeline (
  input  logic                  clock,
  input  logic                  reset,
  input  pipe_pkg::inst_t       inst,          // one instruction per valid cycle
  input  logic                  inst_valid,
  output logic                  commit_valid,
  output logic                  commit_wr_en,
  output pipe_pkg::reg_idx_t    commit_wr_idx,
  output pipe_pkg::word_t       commit_wr_data,
  output logic                  halted,
  output pipe_pkg::error_code_e error_status
);
  import pipe_pkg::*;

  // id <-> reg file read ports
  reg_idx_t rf_ra_idx, rf_rb_idx;
  word_t    rf_ra_data, rf_rb_data;

  op_bus_if  op_bus ();    // id/ex register
  res_bus_if res_bus ();   // ex/wb register
  wb_port_if wb_port ();   // write-back, also the forwarding source

  ////////////////////
  // decode
  id_stage id_stage_inst (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_valid (inst_valid),
    .halted     (halted),      // stops fetch acceptance
    .rf_ra_idx  (rf_ra_idx),
    .rf_rb_idx  (rf_rb_idx),
    .rf_ra_data (rf_ra_data),
    .rf_rb_data (rf_rb_data),
    .op         (op_bus)
  );

  reg_file reg_file_inst (
    .clock   (clock),
    .reset   (reset),
    .ra_idx  (rf_ra_idx),
    .rb_idx  (rf_rb_idx),
    .ra_data (rf_ra_data),
    .rb_data (rf_rb_data),
    .wb      (wb_port)
  );

  ////////////////////
  // execute
  ex_stage ex_stage_inst (
    .clock (clock),
    .reset (reset),
    .op    (op_bus),
    .wb    (wb_port),
    .res   (res_bus)
  );

  ////////////////////
  // writeback
  wb_stage wb_stage_inst (
    .clock          (clock),
    .reset          (reset),
    .res            (res_bus),
    .wb             (wb_port),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .halted         (halted),
    .error_status   (error_status)
  );

endmodule

// File: sim/pipeline_tb.sv
// pipeline testbench: table-driven program phases with random bubbles and commit checks
`timescale 1ns/1ps

module pipeline_tb;
  import pipe_pkg::*;

  localparam logic [5:0] INTA = 6'h10;             // addq subq cmpeq
  localparam logic [5:0] INTL = 6'h11;             // and bis xor
  localparam logic [5:0] INTS = 6'h12;             // sll srl
  localparam inst_t HALT_INST    = 32'h0000_0000;  // call_pal halt
  localparam inst_t ILLEGAL_INST = 32'hfc00_0000;  // opcode 3f is not decoded

  // one program step and the commit it should produce
  typedef struct packed {
    inst_t    inst;
    logic     wr_en;
    reg_idx_t idx;
    word_t    data;
    logic     chk_val;   // halting ops carry no meaningful result
  } entry_t;

  logic        clock, reset;
  inst_t       inst;
  logic        inst_valid;
  logic        commit_valid, commit_wr_en, halted;
  reg_idx_t    commit_wr_idx;
  word_t       commit_wr_data;
  error_code_e error_status;

  entry_t      prog[$];            // current phase
  error_code_e exp_err = NO_ERROR;
  int          exp_commits = 0;    // leading entries that commit
  int          phase = 0;
  int          seen = 0;           // commits so far in this phase
  int          gap, errs_before;
  int          tests = 0;
  int          failed = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;    // grows with each loaded phase
  int unsigned lcg_state = 77654;

  pipeline pipeline_inst (
    .clock          (clock),
    .reset          (reset),
    .inst           (inst),
    .inst_valid     (inst_valid),
    .commit_valid   (commit_valid),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .halted         (halted),
    .error_status   (error_status)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;   // 100 ns period
  end

  ////////////////////
  // helpers
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;       // upper bits are less periodic
  endfunction

  // operate format with literal in 20:13 and bit 12 set
  function automatic inst_t lit_inst(logic [5:0] opc, logic [6:0] fn, reg_idx_t ra,
                                     lit_t lit, reg_idx_t rc);
    return {opc, ra, lit, 1'b1, fn, rc};
  endfunction

  function automatic inst_t reg_inst(logic [5:0] opc, logic [6:0] fn, reg_idx_t ra,
                                     reg_idx_t rb, reg_idx_t rc);
    return {opc, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  task automatic add_entry(inst_t i, logic en, reg_idx_t idx, word_t d, logic chk = 1'b1);
    prog.push_back('{inst: i, wr_en: en, idx: idx, data: d, chk_val: chk});
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input error_code_e got, input error_code_e exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // program tables
  task automatic load_phase(input int p);
    prog.delete();
    case (p)
      1: begin
        // literals through bis, addq, subq, shifts, cmpeq
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd5, 5'd1), 1'b1, 5'd1, 64'h5);
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd200, 5'd2), 1'b1, 5'd2, 64'hc8);
        add_entry(lit_inst(INTA, 7'h20, 5'd1, 8'd10, 5'd3), 1'b1, 5'd3, 64'hf);
        add_entry(lit_inst(INTA, 7'h29, 5'd3, 8'd20, 5'd4), 1'b1, 5'd4, 64'hffff_ffff_ffff_fffb);
        add_entry(lit_inst(INTS, 7'h39, 5'd2, 8'd4, 5'd5), 1'b1, 5'd5, 64'hc80);
        add_entry(lit_inst(INTS, 7'h34, 5'd5, 8'd8, 5'd15), 1'b1, 5'd15, 64'hc);
        add_entry(lit_inst(INTA, 7'h2d, 5'd1, 8'd5, 5'd6), 1'b1, 5'd6, 64'h1);
        add_entry(lit_inst(INTA, 7'h2d, 5'd1, 8'd6, 5'd7), 1'b1, 5'd7, 64'h0);
        // back to back with r8 feeding both operands
        add_entry(lit_inst(INTA, 7'h20, 5'd7, 8'd1, 5'd8), 1'b1, 5'd8, 64'h1);
        add_entry(reg_inst(INTA, 7'h20, 5'd8, 5'd8, 5'd9), 1'b1, 5'd9, 64'h2);
        add_entry(reg_inst(INTA, 7'h29, 5'd9, 5'd1, 5'd10), 1'b1, 5'd10, 64'hffff_ffff_ffff_fffd);
        // xor/and chain with distance two on a then on b
        add_entry(reg_inst(INTL, 7'h40, 5'd1, 5'd2, 5'd11), 1'b1, 5'd11, 64'hcd);
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd15, 5'd12), 1'b1, 5'd12, 64'hf);
        add_entry(reg_inst(INTL, 7'h00, 5'd11, 5'd12, 5'd13), 1'b1, 5'd13, 64'hd);
        add_entry(reg_inst(INTL, 7'h40, 5'd11, 5'd12, 5'd14), 1'b1, 5'd14, 64'hc2);
        // r31 write is dropped and reads stay zero
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'h55, 5'd31), 1'b0, 5'd31, 64'h55);
        add_entry(lit_inst(INTA, 7'h20, 5'd31, 8'd3, 5'd16), 1'b1, 5'd16, 64'h3);
        add_entry(reg_inst(INTA, 7'h20, 5'd31, 5'd31, 5'd17), 1'b1, 5'd17, 64'h0);
        exp_commits = 18;
        exp_err     = NO_ERROR;
      end
      2: begin
        add_entry(HALT_INST, 1'b0, 5'd0, 64'h0, 1'b0);
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd1, 5'd1), 1'b1, 5'd1, 64'h1);   // dropped
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd2, 5'd2), 1'b1, 5'd2, 64'h2);   // dropped
        exp_commits = 1;
        exp_err     = HALTED_ON_HALT;
      end
      default: begin
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd7, 5'd1), 1'b1, 5'd1, 64'h7);
        add_entry(ILLEGAL_INST, 1'b0, 5'd0, 64'h0, 1'b0);
        add_entry(lit_inst(INTL, 7'h20, 5'd31, 8'd9, 5'd2), 1'b1, 5'd2, 64'h9);   // dropped
        exp_commits = 2;
        exp_err     = HALTED_ON_ILLEGAL;
      end
    endcase
    cycle_limit += prog.size() * 4 + 20;
  endtask

  ////////////////////
  // one phase resets, feeds with bubbles and waits for commits
  task automatic run_phase(input int p);
    @(posedge clock);
    reset      <= 1'b1;
    inst_valid <= 1'b0;
    phase = p;
    seen  = 0;
    load_phase(p);
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    foreach (prog[i]) begin
      gap = lcg_next() % 3;        // 0..2 idle cycles
      repeat (gap) begin
        @(posedge clock);
        inst_valid <= 1'b0;
      end
      @(posedge clock);
      inst       <= prog[i].inst;
      inst_valid <= 1'b1;
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    while (seen < exp_commits) @(posedge clock);
    repeat (6) @(posedge clock);   // stray commits behind a halt would show here
    @(negedge clock);
    check_flag("halted", halted, exp_err != NO_ERROR);
    check_err("error_status", error_status, exp_err);
    $display("phase %0d done: halted %b, error_status %s", p, halted, error_status.name());
  endtask

  ////////////////////
  // commit monitor sampled mid-cycle
  always @(negedge clock) begin
    if (!reset && commit_valid) begin
      if (seen >= exp_commits) begin
        $display("phase %0d: commit seen after the halting instruction", phase);
        errors++;
      end else begin
        errs_before = errors;
        check_flag("commit_wr_en", commit_wr_en, prog[seen].wr_en);
        if (prog[seen].chk_val) begin
          check_idx("commit_wr_idx", commit_wr_idx, prog[seen].idx);
          check_word("commit_wr_data", commit_wr_data, prog[seen].data);
        end
        tests++;
        if (errors != errs_before) failed++;
        $display("phase %0d entry %0d inst %h: %s", phase, seen, prog[seen].inst,
                 (errors == errs_before) ? "ok" : "mismatch");
      end
      seen++;
    end
  end

  // run limit from table length
  always @(posedge clock) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout in phase %0d after %0d cycles, commits missing", phase, cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    reset      = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    for (int p = 1; p <= 3; p++) run_phase(p);
    $display("entries %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: pipeline.f
+incdir+common
common/pipe_pkg.sv
common/stage_if.sv
decode/reg_file.sv
decode/id_stage.sv
verilog/ex_stage.sv
verilog/wb_stage.sv
verilog/pipeline.sv
sim/pipeline_tb.sv

// File: Makefile
TOP = pipeline_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -j 0 --assert --top-module $(TOP) -f pipeline.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
